/* rv_core.f */
+incdir+.
rv_core_pkg.sv
rv_fetch.sv
rv_regfile.sv
rv_execute.sv
rv_retire.sv
rv_core.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  -f rv_core.f --top-module tb_rv_core -o sim_tb_rv_core
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_tb_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tb_rv_core.sv */
// Self-checking testbench; fetches beyond the fixed-seed 60-word program are never acked
`include "rv_core_macros.svh"

module tb_rv_core
  import rv_core_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PROG_LEN    = 60;
  localparam int WATCHDOG_NS = PROG_LEN * 20 * 8;

  logic         clk;
  logic         rst_n;
  logic         imem_req_o;
  logic [31:0]  imem_adr_o;
  logic         imem_ack_i;
  logic [31:0]  imem_insn_i;
  logic         retire_req_o;
  retire_item_t retire_o;
  logic         retire_ack_i;

  integer       seed = 32'he0c0484c;
  logic [31:0]  prog [PROG_LEN];
  int           fetch_dly [PROG_LEN];
  int           ret_dly [PROG_LEN];
  logic [31:0]  mirror [32];      // Reference register file
  int           fetched = 0;
  int           retired = 0;
  int           checks = 0;
  int           errors = 0;

  rv_core DUT (
    .clk_i        ( clk          ),
    .rst_n_i      ( rst_n        ),
    .imem_req_o   ( imem_req_o   ),
    .imem_adr_o   ( imem_adr_o   ),
    .imem_ack_i   ( imem_ack_i   ),
    .imem_insn_i  ( imem_insn_i  ),
    .retire_req_o ( retire_req_o ),
    .retire_o     ( retire_o     ),
    .retire_ack_i ( retire_ack_i ) );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  //
  // Error reporting and encoding helpers
  //
  task automatic value_error(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic protocol_error(input string msg);
    errors++;
    $display("Protocol error at %0t: %s", $time, msg);
  endtask

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
  endfunction

  function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1);
    return {imm, rs1, f3, rd, `RV_OPC_OPIMM};
  endfunction

  function automatic logic [31:0] pc_of(input int n);
    return `RV_PC_INIT + 32'(4 * n);
  endfunction

  // Returns 1 for a supported word and its result from the mirrored registers
  function automatic logic model_result(input logic [31:0] w, output logic [31:0] res);
    logic [31:0] a;
    logic [31:0] b;
    logic        sub;
    a   = mirror[w[19:15]];
    b   = '0;
    sub = 1'b0;
    res = '0;
    if (w[6:0] == `RV_OPC_OP)
    begin
      b = mirror[w[24:20]];
      if (w[31:25] == 7'h20 && w[14:12] == 3'b000)
        sub = 1'b1;
      else if (w[31:25] != 7'h00)
        return 1'b0;
    end
    else if (w[6:0] == `RV_OPC_OPIMM)
      b = {{20{w[31]}}, w[31:20]};
    else
      return 1'b0;
    case (w[14:12])
      3'b000:  res = sub ? a - b : a + b;
      3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  res = a ^ b;
      3'b110:  res = a | b;
      3'b111:  res = a & b;
      default: return 1'b0;        // Shifts and SLTU
    endcase
    return 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  //
  // Program and delays
  //
  task automatic build_program();
    int          sel;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    foreach (mirror[r])
      mirror[r] = '0;
    for (int k = 1; k < 8; k++)    // x1..x7 get values of both signs
      prog[k-1] = itype_word(12'(k * 37 - 150), 3'b000, 5'(k), 5'd0);
    prog[7]  = rtype_word(7'h20, 3'b000, 5'd1, 5'd2, 5'd7);  // Negative difference
    prog[8]  = rtype_word(7'h00, 3'b010, 5'd3, 5'd1, 5'd5);  // Signed compare
    prog[9]  = itype_word(12'd1, 3'b010, 5'd4, 5'd4);
    prog[10] = itype_word(12'd7, 3'b000, 5'd0, 5'd5);        // Write to x0
    prog[11] = rtype_word(7'h00, 3'b000, 5'd6, 5'd0, 5'd5);
    prog[12] = {12'h000, 5'd5, 3'b010, 5'd5, 7'b0000011};    // Load must not touch x5
    prog[13] = rtype_word(7'h00, 3'b000, 5'd7, 5'd5, 5'd0);
    for (int i = 14; i < PROG_LEN; i++)
    begin
      sel = $unsigned($random(seed)) % 12;
      rd  = 5'($random(seed) & 7);
      rs1 = 5'($random(seed) & 7);
      rs2 = 5'($random(seed) & 7);
      imm = 12'($random(seed) & 63) - 12'd32;
      case (sel)
        0:  prog[i] = rtype_word(7'h00, 3'b000, rd, rs1, rs2);
        1:  prog[i] = rtype_word(7'h20, 3'b000, rd, rs1, rs2);
        2:  prog[i] = rtype_word(7'h00, 3'b010, rd, rs1, rs2);
        3:  prog[i] = rtype_word(7'h00, 3'b100, rd, rs1, rs2);
        4:  prog[i] = rtype_word(7'h00, 3'b110, rd, rs1, rs2);
        5:  prog[i] = rtype_word(7'h00, 3'b111, rd, rs1, rs2);
        6:  prog[i] = itype_word(imm, 3'b000, rd, rs1);
        7:  prog[i] = itype_word(imm, 3'b010, rd, rs1);
        8:  prog[i] = itype_word(imm, 3'b100, rd, rs1);
        9:  prog[i] = itype_word(imm, 3'b110, rd, rs1);
        10: prog[i] = itype_word(imm, 3'b111, rd, rs1);
        default:
        begin
          case (rs2[1:0])
            2'd0:    prog[i] = {imm, rs1, 3'b000, rd, 7'b0110111};  // LUI
            2'd1:    prog[i] = rtype_word(7'h00, 3'b001, rd, rs1, rs2);
            2'd2:    prog[i] = rtype_word(7'h01, 3'b000, rd, rs1, rs2);
            default: prog[i] = {imm, rs1, 3'b010, rd, 7'b0100011};  // Store
          endcase
        end
      endcase
    end
    for (int i = 0; i < PROG_LEN; i++)
    begin
      fetch_dly[i] = $unsigned($random(seed)) % 4;
      ret_dly[i]   = $unsigned($random(seed)) % 6;
    end
  endtask

  task automatic check_retire(input retire_item_t it, input int n);
    logic [31:0] w;
    logic [31:0] exp_res;
    logic        legal;
    w     = prog[n];
    legal = model_result(w, exp_res);
    checks++;
    assert (it.pc == pc_of(n))
      else value_error($sformatf("item %0d pc %h, expected %h", n, it.pc, pc_of(n)));
    assert (it.rd == w[11:7])
      else value_error($sformatf("item %0d rd %0d, expected %0d", n, it.rd, w[11:7]));
    assert (it.illegal == !legal)
      else value_error($sformatf("item %0d illegal %0b for word %h", n, it.illegal, w));
    if (legal)
    begin
      assert (it.result == exp_res)
        else value_error($sformatf("item %0d result %h, expected %h", n, it.result, exp_res));
      if (w[11:7] != 5'd0)
        mirror[w[11:7]] = exp_res;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  //
  // Port agents
  //
  initial
  begin : fetch_responder
    imem_ack_i  = 1'b0;
    imem_insn_i = '0;
    forever
    begin
      @(posedge clk);
      if (rst_n && imem_req_o && !imem_ack_i && fetched < PROG_LEN)
      begin
        assert (imem_adr_o == pc_of(fetched))
          else value_error($sformatf("fetch address %h, expected %h", imem_adr_o,
                                     pc_of(fetched)));
        repeat (fetch_dly[fetched]) @(posedge clk);
        imem_insn_i <= prog[fetched];
        imem_ack_i  <= 1'b1;
        fetched++;
        @(posedge clk);
        while (imem_req_o)
          @(posedge clk);
        imem_ack_i <= 1'b0;
      end
    end
  end

  initial
  begin : retire_consumer
    retire_item_t item;
    retire_ack_i = 1'b0;
    forever
    begin
      @(posedge clk);
      if (rst_n && retire_req_o && !retire_ack_i)
      begin
        repeat (ret_dly[retired % PROG_LEN]) @(posedge clk);
        item = retire_o;            // Must still be the presented item
        if (retired < PROG_LEN)
          check_retire(item, retired);
        else
          protocol_error("an item retired beyond the end of the program");
        retired++;
        retire_ack_i <= 1'b1;
        @(posedge clk);
        while (retire_req_o)
          @(posedge clk);
        retire_ack_i <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  //
  // Reset and handshake properties
  //
  assert property (@(posedge clk) !rst_n |-> !imem_req_o && !retire_req_o)
    else protocol_error("a request is high during reset");
  assert property (@(posedge clk) $rose(rst_n) |-> !imem_req_o && !retire_req_o)
    else protocol_error("a request is high in the first cycle after reset");
  assert property (@(posedge clk) $rose(rst_n) |=> imem_req_o && imem_adr_o == `RV_PC_INIT)
    else value_error("first fetch is not a request at the reset address");

  assert property (@(posedge clk) disable iff (!rst_n)
                   imem_req_o && !imem_ack_i |=> imem_req_o)
    else protocol_error("fetch request dropped before ack rose");
  assert property (@(posedge clk) disable iff (!rst_n)
                   !imem_req_o && imem_ack_i |=> !imem_req_o)
    else protocol_error("fetch request raised while ack was still high");
  assert property (@(posedge clk) disable iff (!rst_n)
                   imem_req_o |=> !imem_req_o || $stable(imem_adr_o))
    else protocol_error("fetch address changed while request was high");

  assert property (@(posedge clk) disable iff (!rst_n)
                   retire_req_o && !retire_ack_i |=> retire_req_o)
    else protocol_error("retire request dropped before ack rose");
  assert property (@(posedge clk) disable iff (!rst_n)
                   !retire_req_o && retire_ack_i |=> !retire_req_o)
    else protocol_error("retire request raised while ack was still high");
  assert property (@(posedge clk) disable iff (!rst_n)
                   retire_req_o |=> !retire_req_o || $stable(retire_o))
    else protocol_error("retire data changed while request was high");

  //////////////////////////////////////////////////////////////////////
  //
  // Run control
  //
  initial
  begin : main
    rst_n = 1'b0;
    build_program();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    while (retired < PROG_LEN)
      @(posedge clk);
    repeat (30) @(posedge clk);     // Nothing else may retire
    assert (fetched == PROG_LEN && retired == PROG_LEN)
      else protocol_error($sformatf("%0d items fetched and %0d retired for %0d words",
                                    fetched, retired, PROG_LEN));
    $display("Retired %0d of %0d items, %0d item checks, %0d errors",
             retired, PROG_LEN, checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with %0d of %0d items retired",
             WATCHDOG_NS, retired, PROG_LEN);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* rv_core.sv */
// Core top; fetch, execute and retire in order with at most three items in flight
`include "rv_core_macros.svh"

module rv_core
  import rv_core_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,

  // Instruction port
  output logic                imem_req_o,
  output logic [`RV_XLEN-1:0] imem_adr_o,
  input  logic                imem_ack_i,
  input  logic [`RV_XLEN-1:0] imem_insn_i,

  // Retire port
  output logic                retire_req_o,
  output retire_item_t        retire_o,
  input  logic                retire_ack_i
);

  fetch_item_t           fetch_item;
  logic                  fetch_valid;
  logic                  fetch_ready;
  retire_item_t          ex_item;
  logic                  ex_valid;
  logic                  retire_ready;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_XLEN-1:0]   rdata1;
  logic [`RV_XLEN-1:0]   rdata2;
  logic                  rf_we;
  logic [`RV_REG_AW-1:0] rf_rd;
  logic [`RV_XLEN-1:0]   rf_wdata;

  rv_fetch u_fetch (
    .clk_i         ( clk_i        ),
    .rst_n_i       ( rst_n_i      ),
    .imem_req_o    ( imem_req_o   ),
    .imem_adr_o    ( imem_adr_o   ),
    .imem_ack_i    ( imem_ack_i   ),
    .imem_insn_i   ( imem_insn_i  ),
    .fetch_item_o  ( fetch_item   ),
    .fetch_valid_o ( fetch_valid  ),
    .fetch_ready_i ( fetch_ready  ) );

  rv_execute u_execute (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .fetch_item_i   ( fetch_item   ),
    .fetch_valid_i  ( fetch_valid  ),
    .fetch_ready_o  ( fetch_ready  ),
    .rs1_o          ( rs1          ),
    .rs2_o          ( rs2          ),
    .rdata1_i       ( rdata1       ),
    .rdata2_i       ( rdata2       ),
    .rf_we_o        ( rf_we        ),
    .rf_rd_o        ( rf_rd        ),
    .rf_wdata_o     ( rf_wdata     ),
    .retire_item_o  ( ex_item      ),
    .retire_valid_o ( ex_valid     ),
    .retire_ready_i ( retire_ready ) );

  // Written on the same edge that hands the result to retire
  rv_regfile u_regfile (
    .clk_i    ( clk_i    ),
    .rst_n_i  ( rst_n_i  ),
    .rs1_i    ( rs1      ),
    .rs2_i    ( rs2      ),
    .rdata1_o ( rdata1   ),
    .rdata2_o ( rdata2   ),
    .we_i     ( rf_we    ),
    .rd_i     ( rf_rd    ),
    .wdata_i  ( rf_wdata ) );

  rv_retire u_retire (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .retire_item_i  ( ex_item      ),
    .retire_valid_i ( ex_valid     ),
    .retire_ready_o ( retire_ready ),
    .retire_req_o   ( retire_req_o ),
    .retire_o       ( retire_o     ),
    .retire_ack_i   ( retire_ack_i ) );

endmodule

/* rv_retire.sv */
// Retire side; one item at a time, next item only after the four-phase cycle has closed
module rv_retire
  import rv_core_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,

  // From execute
  input  retire_item_t retire_item_i,
  input  logic         retire_valid_i,
  output logic         retire_ready_o,

  // Four-phase retire port
  output logic         retire_req_o,
  output retire_item_t retire_o,
  input  logic         retire_ack_i
);

  retire_item_t item_q;
  logic         req_q;
  logic         busy_q;   // Item held until ack is back low
  logic         accept;

  assign accept = retire_valid_i & ~busy_q;

  //////////////////////////////////////////////////////////////////////
  //
  // Handshake control
  //
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      req_q  <= 1'b0;
      busy_q <= 1'b0;
    end
    else if (accept)
    begin
      req_q  <= 1'b1;
      busy_q <= 1'b1;
    end
    else if (req_q && retire_ack_i)
      req_q <= 1'b0;                 // Consumer has it
    else if (busy_q && !req_q && !retire_ack_i)
      busy_q <= 1'b0;                // Cycle closed
  end

  // Payload only
  always_ff @(posedge clk_i)
  begin
    if (accept)
      item_q <= retire_item_i;
  end

  assign retire_ready_o = ~busy_q;
  assign retire_req_o   = req_q;
  assign retire_o       = item_q;   // Stable while req is high

endmodule

/* rv_execute.sv */
// Execute; one item per cycle, ALU subset ADD SUB SLT XOR OR AND plus immediates, no forwarding
`include "rv_core_macros.svh"

module rv_execute
  import rv_core_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // From fetch
  input  fetch_item_t           fetch_item_i,
  input  logic                  fetch_valid_i,
  output logic                  fetch_ready_o,

  // Register file
  output logic [`RV_REG_AW-1:0] rs1_o,
  output logic [`RV_REG_AW-1:0] rs2_o,
  input  logic [`RV_XLEN-1:0]   rdata1_i,
  input  logic [`RV_XLEN-1:0]   rdata2_i,
  output logic                  rf_we_o,
  output logic [`RV_REG_AW-1:0] rf_rd_o,
  output logic [`RV_XLEN-1:0]   rf_wdata_o,

  // To retire
  output retire_item_t          retire_item_o,
  output logic                  retire_valid_o,
  input  logic                  retire_ready_i
);

  fetch_item_t         item_q;
  logic                valid_q;
  insn_u               insn;
  logic                is_op;
  logic                is_opimm;
  alu_op_e             alu_op;
  logic [`RV_XLEN-1:0] imm_sext;
  logic [`RV_XLEN-1:0] opb;
  logic [`RV_XLEN-1:0] result;
  logic                illegal;

  //////////////////////////////////////////////////////////////////////
  //
  // Item register
  //
  assign fetch_ready_o = ~valid_q | retire_ready_i;  // Hold while retire is busy

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      valid_q <= 1'b0;
    else if (fetch_ready_o)
      valid_q <= fetch_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (fetch_ready_o && fetch_valid_i)
      item_q <= fetch_item_i;
  end

  //////////////////////////////////////////////////////////////////////
  //
  // Decode
  //
  assign insn     = item_q.insn;
  assign is_op    = (insn.r.opcode == `RV_OPC_OP);
  assign is_opimm = (insn.i.opcode == `RV_OPC_OPIMM);

  always_comb
  begin
    alu_op = ALU_NONE;
    if (is_opimm || (is_op && insn.r.funct7 == 7'b0000000))
    begin
      case (insn.r.funct3)
        3'b000:  alu_op = ALU_ADD;
        3'b010:  alu_op = ALU_SLT;
        3'b100:  alu_op = ALU_XOR;
        3'b110:  alu_op = ALU_OR;
        3'b111:  alu_op = ALU_AND;
        default: alu_op = ALU_NONE;  // Shifts and SLTU not supported
      endcase
    end
    else if (is_op && insn.r.funct7 == 7'b0100000 && insn.r.funct3 == 3'b000)
      alu_op = ALU_SUB;              // Only funct7 bit 5 user
  end

  assign illegal = (alu_op == ALU_NONE);

  //////////////////////////////////////////////////////////////////////
  //
  // Operands and ALU
  //
  assign rs1_o    = insn.r.rs1;
  assign rs2_o    = insn.r.rs2;
  assign imm_sext = {{(`RV_XLEN-12){insn.i.imm12[11]}}, insn.i.imm12};
  assign opb      = is_op ? rdata2_i : imm_sext;

  always_comb
  begin
    case (alu_op)
      ALU_ADD: result = rdata1_i + opb;
      ALU_SUB: result = rdata1_i - opb;
      ALU_SLT: result = {{(`RV_XLEN-1){1'b0}}, $signed(rdata1_i) < $signed(opb)};
      ALU_XOR: result = rdata1_i ^ opb;
      ALU_OR:  result = rdata1_i | opb;
      ALU_AND: result = rdata1_i & opb;
      default: result = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  //
  // Outputs
  //

  // Register write lands on the hand-off edge
  assign rf_we_o    = valid_q & retire_ready_i & ~illegal;
  assign rf_rd_o    = insn.r.rd;
  assign rf_wdata_o = result;

  assign retire_item_o.pc      = item_q.pc;
  assign retire_item_o.rd      = insn.r.rd;
  assign retire_item_o.result  = result;
  assign retire_item_o.illegal = illegal;
  assign retire_valid_o        = valid_q;

endmodule

/* rv_regfile.sv */
// Integer register file; reads are combinational, x0 always reads zero, one write per cycle
`include "rv_core_macros.svh"

module rv_regfile
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Read ports
  input  logic [`RV_REG_AW-1:0] rs1_i,
  input  logic [`RV_REG_AW-1:0] rs2_i,
  output logic [`RV_XLEN-1:0]   rdata1_o,
  output logic [`RV_XLEN-1:0]   rdata2_o,

  // Write port
  input  logic                  we_i,
  input  logic [`RV_REG_AW-1:0] rd_i,
  input  logic [`RV_XLEN-1:0]   wdata_i
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  //////////////////////////////////////////////////////////////////////
  //
  // Write
  //
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < `RV_NREGS; i++)
        regs[i] <= '0;
    end
    else if (we_i && rd_i != '0)    // x0 silently dropped
      regs[rd_i] <= wdata_i;
  end

  //////////////////////////////////////////////////////////////////////
  //
  // Read
  //

  // Same-edge writes are visible to the next reader
  assign rdata1_o = regs[rs1_i];
  assign rdata2_o = regs[rs2_i];

endmodule

/* rv_fetch.sv */
// Fetch side; one request in flight on a four-phase port, pc strictly sequential (no branches)
`include "rv_core_macros.svh"

module rv_fetch
  import rv_core_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,

  // Four-phase instruction port
  output logic                imem_req_o,
  output logic [`RV_XLEN-1:0] imem_adr_o,
  input  logic                imem_ack_i,
  input  logic [`RV_XLEN-1:0] imem_insn_i,

  // To execute
  output fetch_item_t         fetch_item_o,
  output logic                fetch_valid_o,
  input  logic                fetch_ready_i
);

  logic [`RV_XLEN-1:0] pc_q;
  logic                req_q;
  logic                valid_q;
  fetch_item_t         item_q;
  logic                capture;
  logic                start;

  //////////////////////////////////////////////////////////////////////
  //
  // Handshake control
  //

  // Ack seen while requesting, take the word and drop req
  assign capture = req_q & imem_ack_i;

  // Previous cycle fully closed and room for the next word
  assign start = ~req_q & ~imem_ack_i & (~valid_q | fetch_ready_i);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      req_q <= 1'b0;
      pc_q  <= `RV_PC_INIT;
    end
    else if (capture)
    begin
      req_q <= 1'b0;
      pc_q  <= pc_q + `RV_XLEN'd4;  // Next sequential word
    end
    else if (start)
      req_q <= 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  //
  // Item buffer
  //
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      valid_q <= 1'b0;
    else if (capture)
      valid_q <= 1'b1;
    else if (fetch_ready_i)
      valid_q <= 1'b0;              // Taken by execute
  end

  // Payload only
  always_ff @(posedge clk_i)
  begin
    if (capture)
    begin
      item_q.pc   <= pc_q;
      item_q.insn <= imem_insn_i;
    end
  end

  assign imem_req_o    = req_q;
  assign imem_adr_o    = pc_q;      // Stable while req is high
  assign fetch_item_o  = item_q;
  assign fetch_valid_o = valid_q;

endmodule

/* rv_core_pkg.sv */
// Core types; the item structs assume RV_XLEN of 32 and 32-bit uncompressed instructions
`include "rv_core_macros.svh"

package rv_core_pkg;

  //////////////////////////////////////////////////////////////////////
  //
  // Instruction formats
  //

  // Register-register layout
  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } r_type_t;

  // Register-immediate layout
  typedef struct packed {
    logic [11:0]           imm12;   // Sign extended in execute
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } i_type_t;

  // One word, two views; opcode picks which one is meaningful
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } insn_u;

  //////////////////////////////////////////////////////////////////////
  //
  // ALU operations
  //
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_NONE              // Unsupported encoding
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////
  //
  // Stage-to-stage items
  //
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    insn_u               insn;
  } fetch_item_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   result;
    logic                  illegal;  // Set for any encoding outside the ALU subset
  } retire_item_t;

endpackage

/* rv_core_macros.svh */
// Core-wide constants; only RV32 with 32 registers and the OP/OP-IMM opcode groups are covered
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
//
// Datapath sizes
//
`define RV_XLEN      32             // Data and address width
`define RV_NREGS     32             // Integer registers, x0 included
`define RV_REG_AW    5              // Register index width

//////////////////////////////////////////////////////////////////////
//
// Reset vector
//
`define RV_PC_INIT   32'h0000_0200  // First fetch address

//////////////////////////////////////////////////////////////////////
//
// Major opcodes
//
// Register-register and register-immediate integer groups
`define RV_OPC_OP    7'b0110011
`define RV_OPC_OPIMM 7'b0010011

`endif
